// ==== verilog/div_pkg.sv ====
package div_pkg;

    // Architectural data width of the core
    localparam int XLEN = 64;

    // One quotient bit is produced per iteration, word forms included
    localparam int DIV_ITERS = 64;

    // 64-bit operand and result word
    typedef logic [XLEN-1:0] xlen_t;

    // Low half of an operand, used by the W operations
    typedef logic [XLEN/2-1:0] half_t;

    // Iteration counter, wide enough to hold DIV_ITERS itself
    typedef logic [6:0] iter_cnt_t;

    // Partial remainder in the upper half and quotient in the lower half
    typedef logic [2*XLEN-1:0] acc_t;

    // Counter value seen during the final RUN cycle
    localparam iter_cnt_t DIV_ITER_LAST = iter_cnt_t'(DIV_ITERS - 1);

    // M-extension divide operations, the W form is selected separately
    typedef enum logic [1:0] {
        DIV  = 2'd0,
        DIVU = 2'd1,
        REM  = 2'd2,
        REMU = 2'd3
    } div_op_e;

    // Serial core states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } core_state_e;

endpackage

// ==== verilog/div_operand_prep.sv ====
`timescale 1ns/10ps

module div_operand_prep (
    input  div_pkg::div_op_e op,
    input  logic             word,
    input  div_pkg::xlen_t   dividend,
    input  div_pkg::xlen_t   divisor,
    output div_pkg::xlen_t   abs_dividend,
    output div_pkg::xlen_t   abs_divisor,
    output logic             quot_neg,
    output logic             rem_neg,
    output logic             div_zero,
    output logic             overflow
);
    import div_pkg::*;

    logic  is_signed;
    half_t dvd_lo;
    half_t dvs_lo;
    xlen_t dvd_ext;
    xlen_t dvs_ext;
    logic  dvd_sign;
    logic  dvs_sign;
    logic  dvd_min;
    logic  dvs_minus_one;

    assign is_signed = (op == DIV) || (op == REM);

    assign dvd_lo = dividend[XLEN/2-1:0];
    assign dvs_lo = divisor[XLEN/2-1:0];

    // W forms look only at the low word, extended by the signedness of the op
    always_comb begin
        if (word) begin
            dvd_ext = is_signed ? {{(XLEN/2){dvd_lo[XLEN/2-1]}}, dvd_lo}
                                : {{(XLEN/2){1'b0}}, dvd_lo};
            dvs_ext = is_signed ? {{(XLEN/2){dvs_lo[XLEN/2-1]}}, dvs_lo}
                                : {{(XLEN/2){1'b0}}, dvs_lo};
        end else begin
            dvd_ext = dividend;
            dvs_ext = divisor;
        end
    end

    assign dvd_sign = is_signed && dvd_ext[XLEN-1];
    assign dvs_sign = is_signed && dvs_ext[XLEN-1];

    // Two's-complement magnitudes feed the unsigned core
    assign abs_dividend = dvd_sign ? (~dvd_ext + xlen_t'(1)) : dvd_ext;
    assign abs_divisor  = dvs_sign ? (~dvs_ext + xlen_t'(1)) : dvs_ext;

    assign div_zero = (dvs_ext == '0);

    // Most negative value in the width of the operation, after extension
    assign dvd_min = word ? (dvd_ext == {{(XLEN/2+1){1'b1}}, {(XLEN/2-1){1'b0}}})
                          : (dvd_ext == {1'b1, {(XLEN-1){1'b0}}});
    assign dvs_minus_one = (dvs_ext == '1);  // Holds for both widths once sign-extended

    assign overflow = is_signed && dvd_min && dvs_minus_one;

    assign quot_neg = (dvd_sign ^ dvs_sign) && !div_zero;  // Zero divisor keeps all ones
    assign rem_neg  = dvd_sign;

endmodule

// ==== verilog/div_iter_core.sv ====
`timescale 1ns/10ps

module div_iter_core (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           flush,
    input  div_pkg::xlen_t abs_dividend,
    input  div_pkg::xlen_t abs_divisor,
    output logic           ready,
    output logic           core_done,
    output div_pkg::xlen_t quotient,
    output div_pkg::xlen_t remainder
);
    import div_pkg::*;

    core_state_e state;
    iter_cnt_t   cnt;
    acc_t        acc;
    acc_t        dvs_sh;  // Divisor aligned to the upper half of the accumulator
    acc_t        acc_sh;
    acc_t        acc_nxt;
    logic        fits;
    logic        accept;

    // A flush frees the core, so a start in the same cycle is taken
    assign accept = start && (ready || flush);

    assign ready     = (state == IDLE);
    assign core_done = (state == DONE);

    // One restoring step shifts, trial-subtracts and sets the quotient bit
    assign acc_sh  = acc << 1;
    assign fits    = (acc_sh >= dvs_sh);
    assign acc_nxt = fits ? (acc_sh - dvs_sh + acc_t'(1)) : acc_sh;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else if (accept) begin
            state <= RUN;
            cnt   <= '0;
        end else if (flush) begin
            state <= IDLE;
        end else begin
            case (state)
                RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == DIV_ITER_LAST) begin
                        state <= DONE;  // Last quotient bit lands on this edge
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc    <= {{XLEN{1'b0}}, abs_dividend};
            dvs_sh <= {abs_divisor, {XLEN{1'b0}}};
        end else if ((state == RUN) && !flush) begin
            acc <= acc_nxt;
        end
    end

    assign quotient  = acc[XLEN-1:0];
    assign remainder = acc[2*XLEN-1:XLEN];

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        core_done |=> !core_done)
        else $error("core_done held for more than one cycle");

    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        cnt <= DIV_ITERS)
        else $error("iteration counter beyond %0d", DIV_ITERS);

    // An accepted start keeps ready low for every iteration, then core_done follows
    a_busy_in_run: assert property (@(posedge clk) disable iff (rst || flush)
        accept |=> !ready [*DIV_ITERS] ##1 core_done)
        else $error("division did not run %0d cycles with ready low", DIV_ITERS);

endmodule

// ==== verilog/div_result_fixup.sv ====
`timescale 1ns/10ps

module div_result_fixup (
    input  logic             clk,
    input  logic             rst,
    input  logic             core_done,
    input  logic             flush,
    input  div_pkg::div_op_e op,
    input  logic             word,
    input  logic             quot_neg,
    input  logic             rem_neg,
    input  logic             div_zero,
    input  logic             overflow,
    input  div_pkg::xlen_t   orig_dividend,
    input  div_pkg::xlen_t   quotient,
    input  div_pkg::xlen_t   remainder,
    output logic             out_valid,
    output div_pkg::xlen_t   result
);
    import div_pkg::*;

    xlen_t quot_fix;
    xlen_t rem_fix;
    xlen_t sel;
    xlen_t final_res;
    half_t sel_lo;

    // Signs restored and the architectural special cases applied
    always_comb begin
        quot_fix = quot_neg ? (~quotient + xlen_t'(1)) : quotient;
        rem_fix  = rem_neg ? (~remainder + xlen_t'(1)) : remainder;
        if (div_zero) begin
            quot_fix = '1;
            rem_fix  = orig_dividend;  // Word forms get extended below
        end else if (overflow) begin
            quot_fix = orig_dividend;
            rem_fix  = '0;
        end
    end

    assign sel    = ((op == REM) || (op == REMU)) ? rem_fix : quot_fix;
    assign sel_lo = sel[XLEN/2-1:0];

    // W results are always sign-extended from bit 31, even for DIVUW and REMUW
    assign final_res = word ? {{(XLEN/2){sel_lo[XLEN/2-1]}}, sel_lo} : sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= core_done && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (core_done) begin
            result <= final_res;
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else $error("out_valid held for two cycles");

endmodule

// ==== verilog/div_unit_top.sv ====
`timescale 1ns/10ps

module div_unit_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             flush,
    input  div_pkg::div_op_e op,
    input  logic             word,
    input  div_pkg::xlen_t   dividend,
    input  div_pkg::xlen_t   divisor,
    output logic             ready,
    output logic             out_valid,
    output div_pkg::xlen_t   result
);
    import div_pkg::*;

    xlen_t   abs_dividend;
    xlen_t   abs_divisor;
    logic    quot_neg;
    logic    rem_neg;
    logic    div_zero;
    logic    overflow;
    logic    core_done;
    xlen_t   quotient;
    xlen_t   remainder;
    logic    accept;

    // Request context held for the whole division
    div_op_e op_q;
    logic    word_q;
    logic    quot_neg_q;
    logic    rem_neg_q;
    logic    div_zero_q;
    logic    overflow_q;
    xlen_t   dividend_q;

    assign accept = start && (ready || flush);  // Same rule the core applies

    div_operand_prep prep_i (
        .op           (op),
        .word         (word),
        .dividend     (dividend),
        .divisor      (divisor),
        .abs_dividend (abs_dividend),
        .abs_divisor  (abs_divisor),
        .quot_neg     (quot_neg),
        .rem_neg      (rem_neg),
        .div_zero     (div_zero),
        .overflow     (overflow)
    );

    div_iter_core core_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .flush        (flush),
        .abs_dividend (abs_dividend),
        .abs_divisor  (abs_divisor),
        .ready        (ready),
        .core_done    (core_done),
        .quotient     (quotient),
        .remainder    (remainder)
    );

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q       <= op;
            word_q     <= word;
            quot_neg_q <= quot_neg;
            rem_neg_q  <= rem_neg;
            div_zero_q <= div_zero;
            overflow_q <= overflow;
            dividend_q <= dividend;
        end
    end

    div_result_fixup fixup_i (
        .clk           (clk),
        .rst           (rst),
        .core_done     (core_done),
        .flush         (flush),
        .op            (op_q),
        .word          (word_q),
        .quot_neg      (quot_neg_q),
        .rem_neg       (rem_neg_q),
        .div_zero      (div_zero_q),
        .overflow      (overflow_q),
        .orig_dividend (dividend_q),
        .quotient      (quotient),
        .remainder     (remainder),
        .out_valid     (out_valid),
        .result        (result)
    );

endmodule

// ==== dv/div_tb_clkgen.sv ====
`timescale 1ns/10ps

module div_tb_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // Reset spans five rising edges and is released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== dv/div_unit_tb.sv ====
`timescale 1ns/10ps

module div_unit_tb;
    import div_pkg::*;

    // Divisions issued by the tests below, each given a generous budget
    localparam int PLANNED_DIVS   = 59;
    localparam int TIMEOUT_CYCLES = 200 * PLANNED_DIVS;
    localparam int LATENCY        = 66;

    logic    clk;
    logic    rst;
    logic    start;
    logic    flush;
    div_op_e op;
    logic    word;
    xlen_t   dividend;
    xlen_t   divisor;
    logic    ready;
    logic    out_valid;
    xlen_t   result;
    int      errors;
    int      checks;
    int      cycle_cnt;

    div_tb_clkgen clkgen_i (
        .clk (clk),
        .rst (rst)
    );

    div_unit_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .flush     (flush),
        .op        (op),
        .word      (word),
        .dividend  (dividend),
        .divisor   (divisor),
        .ready     (ready),
        .out_valid (out_valid),
        .result    (result)
    );

    // Expected result from the M-extension rules, quotient truncates toward zero
    function automatic xlen_t ref_result(div_op_e f_op, logic f_word, xlen_t a, xlen_t b);
        logic        is_sig;
        logic        is_rem;
        xlen_t       q;
        xlen_t       r;
        logic [31:0] a32;
        logic [31:0] b32;
        logic [31:0] q32;
        logic [31:0] r32;
        logic [31:0] sel32;
        is_sig = (f_op == DIV) || (f_op == REM);
        is_rem = (f_op == REM) || (f_op == REMU);
        a32 = a[31:0];
        b32 = b[31:0];
        if (f_word) begin
            if (b32 == '0) begin
                q32 = '1;
                r32 = a32;
            end else if (is_sig && (a32 == 32'h8000_0000) && (b32 == '1)) begin
                q32 = a32;  // Signed overflow
                r32 = '0;
            end else if (is_sig) begin
                q32 = $signed(a32) / $signed(b32);
                r32 = $signed(a32) % $signed(b32);
            end else begin
                q32 = a32 / b32;
                r32 = a32 % b32;
            end
            sel32 = is_rem ? r32 : q32;
            return {{32{sel32[31]}}, sel32};
        end
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (is_sig && (a == 64'h8000_0000_0000_0000) && (b == '1)) begin
            q = a;
            r = '0;
        end else if (is_sig) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return is_rem ? r : q;
    endfunction

    task automatic compare_val(string name, logic [63:0] exp, logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected 0x%h, actual 0x%h", name, exp, act);
        end
    endtask

    // Called right after a falling edge, so the request is seen at the next rising edge
    task automatic start_div(string name, div_op_e s_op, logic s_word, xlen_t a, xlen_t b);
        if (!ready) begin
            errors++;
            $display("%s: ready was low when the request was issued", name);
        end
        op       = s_op;
        word     = s_word;
        dividend = a;
        divisor  = b;
        start    = 1'b1;
    endtask

    // Counts falling edges until out_valid, a stray start goes out at poke_at
    task automatic wait_result(string name, xlen_t exp, int poke_at);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 0;
        while (!seen && (cycles < 2 * LATENCY)) begin
            @(negedge clk);
            cycles++;
            start = (cycles == poke_at);
            if (cycles == poke_at) begin
                op       = REMU;
                word     = 1'b0;
                dividend = {$urandom, $urandom};
                divisor  = 64'd1;
            end
            if (out_valid) begin
                seen = 1;
            end else if (ready) begin
                errors++;
                $display("%s: ready went high while the division was running", name);
            end
        end
        if (!seen) begin
            errors++;
            $display("%s: out_valid never arrived", name);
        end else begin
            compare_val(name, exp, result);
            compare_val({name, " latency"}, 64'(LATENCY), 64'(cycles));
        end
    endtask

    task automatic run_div(string name, div_op_e r_op, logic r_word, xlen_t a, xlen_t b,
                           int poke_at = -1);
        xlen_t exp;
        exp = ref_result(r_op, r_word, a, b);
        start_div(name, r_op, r_word, a, b);
        wait_result(name, exp, poke_at);
    endtask

    task automatic basic_ops_64();
        run_div("div_pos", DIV, 1'b0, 64'd100, 64'd7);
        run_div("divu_pos", DIVU, 1'b0, 64'd100, 64'd7);
        run_div("rem_pos", REM, 1'b0, 64'd100, 64'd7);
        run_div("remu_pos", REMU, 1'b0, 64'd100, 64'd7);
        run_div("div_neg_dvd", DIV, 1'b0, -64'sd100, 64'd7);
        run_div("rem_neg_dvd", REM, 1'b0, -64'sd100, 64'd7);
        run_div("div_neg_dvs", DIV, 1'b0, 64'd100, -64'sd7);
        run_div("rem_neg_dvs", REM, 1'b0, 64'd100, -64'sd7);
        run_div("div_neg_both", DIV, 1'b0, -64'sd100, -64'sd7);
        run_div("rem_neg_both", REM, 1'b0, -64'sd100, -64'sd7);
        run_div("divu_max", DIVU, 1'b0, '1, 64'd3);
        run_div("remu_max", REMU, 1'b0, 64'hffff_ffff_ffff_fffb, 64'h10);
    endtask

    task automatic random_ops_64();
        xlen_t a;
        xlen_t b;
        int    i;
        for (i = 0; i < 16; i++) begin
            a = {$urandom, $urandom};
            b = {$urandom, $urandom};
            if (i % 2) b = b >> ($urandom % 60);  // Smaller divisors give wider quotients
            run_div($sformatf("rand64_%0d", i), div_op_e'(i % 4), 1'b0, a, b);
        end
    endtask

    // Upper halves carry junk that the W forms must ignore
    task automatic word_forms();
        xlen_t a;
        xlen_t b;
        int    i;
        run_div("divw", DIV, 1'b1, 64'hdead_beef_ffff_ff9c, 64'h1234_5678_0000_0007);
        run_div("divuw", DIVU, 1'b1, 64'hdead_beef_ffff_ff9c, 64'h1234_5678_0000_0007);
        run_div("remw", REM, 1'b1, 64'hdead_beef_ffff_ff9c, 64'h1234_5678_0000_0007);
        run_div("remuw", REMU, 1'b1, 64'hdead_beef_ffff_ff9c, 64'h1234_5678_0000_0007);
        run_div("divuw_bit31", DIVU, 1'b1, 64'h0000_0001_ffff_fff0, 64'hffff_ffff_0000_0001);
        for (i = 0; i < 8; i++) begin
            a = {$urandom, $urandom};
            b = {$urandom, $urandom};
            b[31:0] = b[31:0] >> (i * 3);
            run_div($sformatf("randw_%0d", i), div_op_e'(i % 4), 1'b1, a, b);
        end
    endtask

    task automatic special_cases();
        run_div("div_zero", DIV, 1'b0, 64'h8765_4321_0fed_cba9, '0);
        run_div("divu_zero", DIVU, 1'b0, 64'h8765_4321_0fed_cba9, '0);
        run_div("rem_zero", REM, 1'b0, 64'h8765_4321_0fed_cba9, '0);
        run_div("remu_zero", REMU, 1'b0, 64'h8765_4321_0fed_cba9, '0);
        run_div("divw_zero", DIV, 1'b1, 64'h1234_5678_8000_0005, 64'hffff_0000_0000_0000);
        run_div("divuw_zero", DIVU, 1'b1, 64'h1234_5678_8000_0005, 64'hffff_0000_0000_0000);
        run_div("remw_zero", REM, 1'b1, 64'h1234_5678_8000_0005, 64'hffff_0000_0000_0000);
        run_div("remuw_zero", REMU, 1'b1, 64'h1234_5678_0000_0005, 64'hffff_0000_0000_0000);
        run_div("div_ovf", DIV, 1'b0, 64'h8000_0000_0000_0000, '1);
        run_div("rem_ovf", REM, 1'b0, 64'h8000_0000_0000_0000, '1);
        run_div("divw_ovf", DIV, 1'b1, 64'h0000_0001_8000_0000, 64'h7777_7777_ffff_ffff);
        run_div("remw_ovf", REM, 1'b1, 64'h0000_0001_8000_0000, 64'h7777_7777_ffff_ffff);
    endtask

    task automatic busy_start_ignored();
        run_div("busy_start", DIVU, 1'b0, 64'h0123_4567_89ab_cdef, 64'h1_0001, 20);
    endtask

    task automatic flush_abort();
        int i;
        start_div("flush_victim", DIV, 1'b0, 64'h7fff_0000_1234_5678, 64'd3);
        @(negedge clk);
        start = 1'b0;
        repeat (9) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        if (!ready) begin
            errors++;
            $display("flush_abort: ready did not return one cycle after the flush");
        end
        for (i = 0; i < LATENCY + 14; i++) begin
            @(negedge clk);
            if (out_valid) begin
                errors++;
                $display("flush_abort: out_valid pulsed after a flushed division");
            end
        end
        run_div("after_flush", REM, 1'b0, -64'sd12345, 64'd77);
    endtask

    // Each request goes out in the out_valid cycle of the one before
    task automatic back_to_back();
        run_div("b2b_first", DIVU, 1'b0, 64'd1000, 64'd9);
        run_div("b2b_second", REM, 1'b1, 64'h0000_0000_ffff_fc18, 64'd9);
        run_div("b2b_third", DIV, 1'b0, -64'sd1000000, 64'd333);
    endtask

    // Watchdog for a DUT that stops answering
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        errors    = 0;
        checks    = 0;
        cycle_cnt = 0;
        start     = 1'b0;
        flush     = 1'b0;
        op        = DIV;
        word      = 1'b0;
        dividend  = '0;
        divisor   = '0;
        void'($urandom(32'h4fdb_5e5e));
        @(negedge clk);
        while (rst) @(negedge clk);
        basic_ops_64();
        random_ops_64();
        word_forms();
        special_cases();
        busy_start_ignored();
        flush_abort();
        back_to_back();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== div_unit.f ====
verilog/div_pkg.sv
verilog/div_operand_prep.sv
verilog/div_iter_core.sv
verilog/div_result_fixup.sv
verilog/div_unit_top.sv
dv/div_tb_clkgen.sv
dv/div_unit_tb.sv

// ==== Bender.yml ====
package:
  name: div_unit

sources:
  # Divide unit RTL in compile order
  - files:
      - verilog/div_pkg.sv
      - verilog/div_operand_prep.sv
      - verilog/div_iter_core.sv
      - verilog/div_result_fixup.sv
      - verilog/div_unit_top.sv

  # Testbench with top module div_unit_tb
  - target: test
    files:
      - dv/div_tb_clkgen.sv
      - dv/div_unit_tb.sv
